/* vlog.f */
icache_pkg.sv
fill_ctrl.sv
cache_way.sv
way_select.sv
icache_top.sv
tb_icache.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_icache
RTL_TOP    := icache_top
FLIST      := vlog.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Test passed

LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;
  import icache_pkg::*;

  localparam int NUM_WAYS = 4;
  localparam int OP_FILL = 0;
  localparam int OP_READ = 1;
  localparam int OP_INV = 2;
  localparam int OP_PROBE = 3;
  localparam int OP_STALL = 4;
  localparam int OP_EXCEPT = 5;
  // cycles after the second fill beat in which an eviction may show
  localparam int EVICT_WINDOW = 6;
  localparam int MAX_CYCLES = 2000;
  // tag and set never filled
  localparam logic [ADDR_WIDTH-1:0] MISS_ADDR = 16'hfff8;

  logic clk;
  logic rst;
  logic read_en;
  logic [ADDR_WIDTH-1:0] read_addr;
  logic read_hit;
  logic [BANK_WIDTH-1:0] read_data;
  logic write_wen;
  logic [ADDR_WIDTH-1:0] write_addr;
  logic [HALF_WIDTH-1:0] write_data;
  logic invalidate;
  logic chk_en;
  logic [ADDR_WIDTH-1:0] chk_addr;
  logic chk_hit;
  logic fstall;
  logic except;
  logic expun_wen;
  logic [ADDR_WIDTH-1:0] expun_addr;

  // stimulus and expected values with one slot per entry
  string t_name[$];
  int t_op[$];
  logic [ADDR_WIDTH-1:0] t_addr[$];
  bit t_hit[$];
  logic [BANK_WIDTH-1:0] t_data[$];
  bit t_evict[$];
  logic [ADDR_WIDTH-1:0] t_evict_addr[$];
  logic [LINE_WIDTH-1:0] t_fill[$];

  // fill values by line indexed by tag and set
  logic [LINE_WIDTH-1:0] shadow [0:8191];

  int errors = 0;
  int checks = 0;
  int failed_tests = 0;

  icache_top #(.NUM_WAYS(NUM_WAYS)) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    for (int i = 0; i < MAX_CYCLES; i++) begin
      @(posedge clk);
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Test failed");
    $finish;
  end

  function automatic logic [ADDR_WIDTH-1:0] make_addr(input logic [TAG_WIDTH-1:0] tag,
                                                      input logic [SET_BITS-1:0] set,
                                                      input logic [BANK_BITS-1:0] bank);
    return {tag, set, bank, 1'b0};
  endfunction

  task automatic add_entry(input string name, input int op, input logic [ADDR_WIDTH-1:0] addr,
                           input bit hit, input bit evict,
                           input logic [ADDR_WIDTH-1:0] evict_addr);
    logic [LINE_WIDTH-1:0] data;
    logic [LINE_WIDTH-1:0] line;
    logic [BANK_WIDTH-1:0] exp_d;
    data = '0;
    exp_d = '0;
    if (op == OP_FILL) begin
      data = {$urandom, $urandom};
      shadow[addr[15:3]] = data;
    end else if (hit) begin
      line = shadow[addr[15:3]];
      exp_d = line[addr[2:1]*BANK_WIDTH +: BANK_WIDTH];
    end
    t_name.push_back(name);
    t_op.push_back(op);
    t_addr.push_back(addr);
    t_hit.push_back(hit);
    t_data.push_back(exp_d);
    t_evict.push_back(evict);
    t_evict_addr.push_back(evict_addr);
    t_fill.push_back(data);
  endtask

  task automatic step_cycle;
    @(posedge clk);
    #1;
  endtask

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      step_cycle();
    end
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("Mismatch %s %s: expected %h, actual %h", name, what, exp, act);
      errors++;
    end
  endtask

  task automatic issue_read(input logic [ADDR_WIDTH-1:0] addr);
    read_en = 1'b1;
    read_addr = addr;
    step_cycle();
    read_en = 1'b0;
  endtask

  task automatic compare_read(input int idx);
    check_value(t_name[idx], "read_hit", 32'(t_hit[idx]), 32'(read_hit));
    check_value(t_name[idx], "read_data", 32'(t_data[idx]), 32'(read_data));
  endtask

  task automatic fill_line(input int idx);
    logic [LINE_WIDTH-1:0] data;
    int cyc;
    int seen_cyc;
    logic [ADDR_WIDTH-1:0] seen_addr;
    data = t_fill[idx];
    seen_cyc = -1;
    seen_addr = '0;
    write_wen = 1'b1;
    write_addr = t_addr[idx];
    write_data = data[HALF_WIDTH-1:0];
    step_cycle();
    write_wen = 1'b0;
    write_data = data[LINE_WIDTH-1:HALF_WIDTH];
    step_cycle();
    write_data = '0;
    cyc = 1;
    while (cyc < EVICT_WINDOW) begin
      step_cycle();
      cyc++;
      if (expun_wen && seen_cyc < 0) begin
        seen_cyc = cyc;
        seen_addr = expun_addr;
      end
    end
    if (t_evict[idx]) begin
      checks++;
      assert (seen_cyc >= 0) else begin
        $display("%s: expun_wen never rose within %0d cycles", t_name[idx], EVICT_WINDOW);
        errors++;
      end
      if (seen_cyc >= 0) begin
        check_value(t_name[idx], "eviction cycle", 32'd3, seen_cyc);
        check_value(t_name[idx], "expun_addr", 32'(t_evict_addr[idx]), 32'(seen_addr));
      end
    end else begin
      check_value(t_name[idx], "expun_wen", 32'd0, 32'(seen_cyc >= 0));
    end
  endtask

  task automatic invalidate_line(input int idx);
    invalidate = 1'b1;
    write_addr = t_addr[idx];
    step_cycle();
    invalidate = 1'b0;
    wait_cycles(2);
    check_value(t_name[idx], "expun_wen", 32'd0, 32'(expun_wen));
  endtask

  task automatic probe_line(input int idx);
    chk_en = 1'b1;
    chk_addr = t_addr[idx];
    step_cycle();
    chk_en = 1'b0;
    wait_cycles(2);
    check_value(t_name[idx], "chk_hit", 32'(t_hit[idx]), 32'(chk_hit));
  endtask

  task automatic stalled_read(input int idx);
    issue_read(t_addr[idx]);
    wait_cycles(2);
    compare_read(idx);
    // a missing read behind the stall must not reach the outputs
    fstall = 1'b1;
    issue_read(MISS_ADDR);
    wait_cycles(3);
    compare_read(idx);
    fstall = 1'b0;
    step_cycle();
  endtask

  task automatic except_read(input int idx);
    issue_read(t_addr[idx]);
    wait_cycles(2);
    compare_read(idx);
    // clear wins over a simultaneous fstall
    fstall = 1'b1;
    except = 1'b1;
    step_cycle();
    except = 1'b0;
    check_value(t_name[idx], "read_hit after except", 32'd0, 32'(read_hit));
    check_value(t_name[idx], "read_data after except", 32'd0, 32'(read_data));
    step_cycle();
    fstall = 1'b0;
  endtask

  initial begin
    int err_before;
    void'($urandom(32'hbcd0));
    rst = 1'b1;
    read_en = 1'b0;
    read_addr = '0;
    write_wen = 1'b0;
    write_addr = '0;
    write_data = '0;
    invalidate = 1'b0;
    chk_en = 1'b0;
    chk_addr = '0;
    fstall = 1'b0;
    except = 1'b0;

    add_entry("fill_a", OP_FILL, make_addr(10'h001, 3'd1, 2'd0), 1'b0, 1'b0, '0);
    for (int b = 0; b < 4; b++) begin
      add_entry($sformatf("read_a_bank%0d", b), OP_READ, make_addr(10'h001, 3'd1, 2'(b)),
                1'b1, 1'b0, '0);
    end
    add_entry("read_unfilled", OP_READ, make_addr(10'h3aa, 3'd2, 2'd1), 1'b0, 1'b0, '0);
    // five tags into set 5 where the last one pushes out the first
    for (int t = 0; t < 5; t++) begin
      add_entry($sformatf("fill_set5_tag%0d", t), OP_FILL,
                make_addr(TAG_WIDTH'(16 + t), 3'd5, 2'd0), 1'b0, t == 4,
                make_addr(10'h010, 3'd5, 2'd0));
    end
    add_entry("read_evicted", OP_READ, make_addr(10'h010, 3'd5, 2'd1), 1'b0, 1'b0, '0);
    add_entry("read_newest", OP_READ, make_addr(10'h014, 3'd5, 2'd3), 1'b1, 1'b0, '0);
    add_entry("inv_tag2", OP_INV, make_addr(10'h012, 3'd5, 2'd0), 1'b0, 1'b0, '0);
    add_entry("read_invalid", OP_READ, make_addr(10'h012, 3'd5, 2'd2), 1'b0, 1'b0, '0);
    add_entry("probe_invalid", OP_PROBE, make_addr(10'h012, 3'd5, 2'd0), 1'b0, 1'b0, '0);
    add_entry("read_other_way", OP_READ, make_addr(10'h013, 3'd5, 2'd1), 1'b1, 1'b0, '0);
    add_entry("read_way1", OP_READ, make_addr(10'h011, 3'd5, 2'd0), 1'b1, 1'b0, '0);
    add_entry("probe_present", OP_PROBE, make_addr(10'h001, 3'd1, 2'd0), 1'b1, 1'b0, '0);
    add_entry("probe_absent", OP_PROBE, make_addr(10'h002, 3'd1, 2'd0), 1'b0, 1'b0, '0);
    add_entry("stall_read", OP_STALL, make_addr(10'h001, 3'd1, 2'd2), 1'b1, 1'b0, '0);
    add_entry("except_read", OP_EXCEPT, make_addr(10'h001, 3'd1, 2'd3), 1'b1, 1'b0, '0);

    wait_cycles(3);
    rst = 1'b0;
    err_before = errors;
    check_value("reset", "read_hit", 32'd0, 32'(read_hit));
    check_value("reset", "read_data", 32'd0, 32'(read_data));
    check_value("reset", "chk_hit", 32'd0, 32'(chk_hit));
    check_value("reset", "expun_wen", 32'd0, 32'(expun_wen));
    check_value("reset", "expun_addr", 32'd0, 32'(expun_addr));
    $display("%-20s %s", "reset", (errors == err_before) ? "ok" : "error");

    for (int i = 0; i < t_name.size(); i++) begin
      err_before = errors;
      case (t_op[i])
        OP_FILL: fill_line(i);
        OP_READ: begin
          issue_read(t_addr[i]);
          wait_cycles(2);
          compare_read(i);
        end
        OP_INV: invalidate_line(i);
        OP_PROBE: probe_line(i);
        OP_STALL: stalled_read(i);
        default: except_read(i);
      endcase
      if (errors != err_before) begin
        failed_tests++;
      end
      $display("%-20s %s", t_name[i], (errors == err_before) ? "ok" : "error");
      step_cycle();
    end

    $display("%0d entries, %0d with errors, %0d checks, %0d errors",
             t_name.size(), failed_tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
  parameter int NUM_WAYS = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic read_en,
  input  logic [icache_pkg::ADDR_WIDTH-1:0] read_addr,
  output logic read_hit,
  output logic [icache_pkg::BANK_WIDTH-1:0] read_data,
  input  logic write_wen,
  input  logic [icache_pkg::ADDR_WIDTH-1:0] write_addr,
  input  logic [icache_pkg::HALF_WIDTH-1:0] write_data,
  input  logic invalidate,
  input  logic chk_en,
  input  logic [icache_pkg::ADDR_WIDTH-1:0] chk_addr,
  output logic chk_hit,
  input  logic fstall,
  input  logic except,
  output logic expun_wen,
  output logic [icache_pkg::ADDR_WIDTH-1:0] expun_addr
);
  import icache_pkg::*;

  // requests broadcast to every way
  logic lookup_en;
  icache_addr_u lookup_addr;
  logic probe_en;
  icache_addr_u probe_addr;
  logic line_wen;
  icache_addr_u line_addr;
  logic [LINE_WIDTH-1:0] line_data;
  logic inv_en;
  logic [NUM_WAYS-1:0] victim_sel;
  logic [BANK_BITS-1:0] bank_sel;

  // per-way results in one slice each
  logic [NUM_WAYS-1:0] way_hit;
  logic [NUM_WAYS*LINE_WIDTH-1:0] way_data;
  logic [NUM_WAYS-1:0] way_probe_hit;
  logic [NUM_WAYS-1:0] victim_valid;
  logic [NUM_WAYS*TAG_WIDTH-1:0] victim_tag;

  fill_ctrl #(.NUM_WAYS(NUM_WAYS)) fill_ctrl_i (.*);

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    cache_way way_i (
      .clk(clk),
      .rst(rst),
      .lookup_en(lookup_en),
      .lookup_addr(lookup_addr),
      .probe_en(probe_en),
      .probe_addr(probe_addr),
      .line_wen(line_wen),
      .line_addr(line_addr),
      .line_data(line_data),
      .inv_en(inv_en),
      .way_wen(victim_sel[w]),
      .way_hit(way_hit[w]),
      .way_data(way_data[w*LINE_WIDTH +: LINE_WIDTH]),
      .way_probe_hit(way_probe_hit[w]),
      .victim_valid(victim_valid[w]),
      .victim_tag(victim_tag[w*TAG_WIDTH +: TAG_WIDTH])
    );
  end

  way_select #(.NUM_WAYS(NUM_WAYS)) way_select_i (.*);

endmodule

/* way_select.sv */
`timescale 1ns/1ps

module way_select #(
  parameter int NUM_WAYS = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic fstall,
  input  logic except,
  input  logic lookup_en,
  input  logic line_wen,
  input  icache_pkg::icache_addr_u line_addr,
  input  logic [icache_pkg::BANK_BITS-1:0] bank_sel,
  input  logic [NUM_WAYS-1:0] victim_sel,
  input  logic [NUM_WAYS-1:0] way_hit,
  input  logic [NUM_WAYS*icache_pkg::LINE_WIDTH-1:0] way_data,
  input  logic [NUM_WAYS-1:0] way_probe_hit,
  input  logic [NUM_WAYS-1:0] victim_valid,
  input  logic [NUM_WAYS*icache_pkg::TAG_WIDTH-1:0] victim_tag,
  output logic read_hit,
  output logic [icache_pkg::BANK_WIDTH-1:0] read_data,
  output logic chk_hit,
  output logic expun_wen,
  output logic [icache_pkg::ADDR_WIDTH-1:0] expun_addr
);
  import icache_pkg::*;

  logic [LINE_WIDTH-1:0] hit_line;
  logic [TAG_WIDTH-1:0] vic_tag;
  logic evict_hit;
  icache_addr_u evict_addr;

  logic hit_q;
  logic probe_q;
  logic [LINE_WIDTH-1:0] line_q;
  logic evict_wen_q;
  logic [ADDR_WIDTH-1:0] evict_addr_q;
  logic [BANK_WIDTH-1:0] bank_word;

  // and-or mux over the ways with at most one hit and one victim
  always_comb begin
    hit_line = '0;
    vic_tag = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_line |= way_data[w*LINE_WIDTH +: LINE_WIDTH] & {LINE_WIDTH{way_hit[w]}};
      vic_tag |= victim_tag[w*TAG_WIDTH +: TAG_WIDTH] & {TAG_WIDTH{victim_sel[w]}};
    end
  end

  // a fill only evicts when the chosen way was holding a line
  assign evict_hit = line_wen & |(victim_sel & victim_valid);

  // line address of the old occupant with bank and offset zero
  always_comb begin
    evict_addr.addr = '0;
    evict_addr.fld.tag = vic_tag;
    evict_addr.fld.set = line_addr.fld.set;
  end

  // first stage
  always_ff @(posedge clk) begin
    if (rst) begin
      hit_q <= 1'b0;
      probe_q <= 1'b0;
      evict_wen_q <= 1'b0;
      evict_addr_q <= '0;
    end else begin
      hit_q <= lookup_en & |way_hit;
      probe_q <= |way_probe_hit;
      evict_wen_q <= evict_hit;
      if (evict_hit) begin
        evict_addr_q <= evict_addr.addr;
      end
    end
  end

  always_ff @(posedge clk) begin
    line_q <= hit_line;
  end

  assign bank_word = line_q[bank_sel*BANK_WIDTH +: BANK_WIDTH];

  // output stage where except wins over fstall
  always_ff @(posedge clk) begin
    if (rst || except) begin
      read_hit <= 1'b0;
      read_data <= '0;
      expun_wen <= 1'b0;
      expun_addr <= '0;
    end else if (!fstall) begin
      read_hit <= hit_q;
      read_data <= hit_q ? bank_word : '0;
      expun_wen <= evict_wen_q;
      expun_addr <= evict_addr_q;
    end
  end

  // probe result bypasses the stall stage
  always_ff @(posedge clk) begin
    if (rst) begin
      chk_hit <= 1'b0;
    end else begin
      chk_hit <= probe_q;
    end
  end

  // a tag lives in at most one way of a set
  a_single_way_hit: assert property (
    @(posedge clk) disable iff (rst) $onehot0(way_hit)
  ) else $error("way_select: more than one way hit");

endmodule

/* cache_way.sv */
`timescale 1ns/1ps

module cache_way (
  input  logic clk,
  input  logic rst,
  input  logic lookup_en,
  input  icache_pkg::icache_addr_u lookup_addr,
  input  logic probe_en,
  input  icache_pkg::icache_addr_u probe_addr,
  input  logic line_wen,
  input  icache_pkg::icache_addr_u line_addr,
  input  logic [icache_pkg::LINE_WIDTH-1:0] line_data,
  input  logic inv_en,
  input  logic way_wen,
  output logic way_hit,
  output logic [icache_pkg::LINE_WIDTH-1:0] way_data,
  output logic way_probe_hit,
  output logic victim_valid,
  output logic [icache_pkg::TAG_WIDTH-1:0] victim_tag
);
  import icache_pkg::*;

  logic [NUM_SETS-1:0] valid;
  logic [TAG_WIDTH-1:0] tag_mem [NUM_SETS];
  logic [LINE_WIDTH-1:0] data_mem [NUM_SETS];

  logic fill_this_way;
  logic inv_match;

  assign fill_this_way = line_wen & way_wen;

  // invalidate hits whichever way holds the tag
  assign inv_match = inv_en & valid[line_addr.fld.set]
                   & (tag_mem[line_addr.fld.set] == line_addr.fld.tag);

  // valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (fill_this_way) begin
      valid[line_addr.fld.set] <= 1'b1;
    end else if (inv_match) begin
      valid[line_addr.fld.set] <= 1'b0;
    end
  end

  // tag and line storage
  always_ff @(posedge clk) begin
    if (fill_this_way) begin
      tag_mem[line_addr.fld.set] <= line_addr.fld.tag;
      data_mem[line_addr.fld.set] <= line_data;
    end
  end

  // fetch lookup sends the whole line out and the bank is picked later
  assign way_hit = lookup_en & valid[lookup_addr.fld.set]
                 & (tag_mem[lookup_addr.fld.set] == lookup_addr.fld.tag);
  assign way_data = data_mem[lookup_addr.fld.set];

  // presence check only
  assign way_probe_hit = probe_en & valid[probe_addr.fld.set]
                       & (tag_mem[probe_addr.fld.set] == probe_addr.fld.tag);

  // current occupant of the fill set before the write lands
  assign victim_valid = valid[line_addr.fld.set];
  assign victim_tag = tag_mem[line_addr.fld.set];

endmodule

/* fill_ctrl.sv */
`timescale 1ns/1ps

module fill_ctrl #(
  parameter int NUM_WAYS = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic read_en,
  input  logic [icache_pkg::ADDR_WIDTH-1:0] read_addr,
  input  logic write_wen,
  input  logic [icache_pkg::ADDR_WIDTH-1:0] write_addr,
  input  logic [icache_pkg::HALF_WIDTH-1:0] write_data,
  input  logic invalidate,
  input  logic chk_en,
  input  logic [icache_pkg::ADDR_WIDTH-1:0] chk_addr,
  output logic lookup_en,
  output icache_pkg::icache_addr_u lookup_addr,
  output logic probe_en,
  output icache_pkg::icache_addr_u probe_addr,
  output logic line_wen,
  output icache_pkg::icache_addr_u line_addr,
  output logic [icache_pkg::LINE_WIDTH-1:0] line_data,
  output logic inv_en,
  output logic [NUM_WAYS-1:0] victim_sel,
  output logic [icache_pkg::BANK_BITS-1:0] bank_sel
);
  import icache_pkg::*;

  localparam int PTR_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

  // bit 0 marks the high-half beat, bit 1 the line write
  logic [1:0] wen_step;
  // round-robin victim pointer per set
  logic [PTR_BITS-1:0] rr_ptr [NUM_SETS];
  logic [PTR_BITS-1:0] cur_ptr;

  assign line_wen = wen_step[1];
  assign cur_ptr = rr_ptr[line_addr.fld.set];

  // request strobes and fill sequencing
  always_ff @(posedge clk) begin
    if (rst) begin
      lookup_en <= 1'b0;
      probe_en <= 1'b0;
      inv_en <= 1'b0;
      wen_step <= 2'b00;
    end else begin
      lookup_en <= read_en;
      probe_en <= chk_en;
      inv_en <= invalidate;
      wen_step <= {wen_step[0], write_wen};
    end
  end

  // request payloads
  always_ff @(posedge clk) begin
    if (read_en) begin
      lookup_addr.addr <= read_addr;
    end
    if (chk_en) begin
      probe_addr.addr <= chk_addr;
    end
    if (write_wen || invalidate) begin
      line_addr.addr <= write_addr;
    end
    // low half first and high half on the following beat
    if (write_wen) begin
      line_data[HALF_WIDTH-1:0] <= write_data;
    end
    if (wen_step[0]) begin
      line_data[LINE_WIDTH-1:HALF_WIDTH] <= write_data;
    end
    // bank field lines up with the read result one stage later
    bank_sel <= lookup_addr.fld.bank;
  end

  // step the set's pointer once its line is written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        rr_ptr[s] <= '0;
      end
    end else if (line_wen) begin
      if (cur_ptr == PTR_BITS'(NUM_WAYS - 1)) begin
        rr_ptr[line_addr.fld.set] <= '0;
      end else begin
        rr_ptr[line_addr.fld.set] <= cur_ptr + 1'b1;
      end
    end
  end

  // one-hot victim for the set being filled
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      victim_sel[w] = (cur_ptr == PTR_BITS'(w));
    end
  end

  // a new fill may not start on the high-half beat of the previous one
  a_no_back_to_back_fill: assert property (
    @(posedge clk) disable iff (rst) wen_step[0] |-> !write_wen
  ) else $error("fill_ctrl: write_wen during second fill beat");

endmodule

/* icache_pkg.sv */
package icache_pkg;

  // fetch address fields from msb to lsb are tag, set, bank and half-word offset
  localparam int ADDR_WIDTH = 16;
  localparam int SET_BITS = 3;
  localparam int BANK_BITS = 2;
  localparam int OFFSET_BITS = 1;
  localparam int TAG_WIDTH = ADDR_WIDTH - SET_BITS - BANK_BITS - OFFSET_BITS;

  // eight sets per way
  localparam int NUM_SETS = 1 << SET_BITS;

  // one line is four 16-bit banks filled as two 32-bit halves
  localparam int LINE_WIDTH = 64;
  localparam int HALF_WIDTH = 32;
  localparam int BANK_WIDTH = 16;

  // fetch address seen flat or as its fields
  typedef union packed {
    // whole word for capture and eviction reporting
    logic [ADDR_WIDTH-1:0] addr;
    // decoded view for indexing and tag compare
    struct packed {
      logic [TAG_WIDTH-1:0] tag;
      logic [SET_BITS-1:0] set;
      logic [BANK_BITS-1:0] bank;
      logic [OFFSET_BITS-1:0] half;
    } fld;
  } icache_addr_u;

endpackage
